// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP        = tb_axi_master_rd
FILELIST   = files.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+hdl
hdl/axi_rd_pkg.sv
hdl/enc_pkg.sv
hdl/rd_cfg_regs.sv
hdl/raddr_channel.sv
hdl/rdata_channel.sv
hdl/axi_master_rd.sv
test/axi_mem_model.sv
test/tb_axi_master_rd.sv

// ==== hdl/axi_master_rd.sv ====
// Read master top. FIFOs are external and AXI side-band fields are constants outside
`include "webp_rd_consts.svh"

module axi_master_rd (
    input  logic                    clk,
    input  logic                    rst_n,
    // APB configuration
    input  logic [7:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    // AXI read address
    output axi_rd_pkg::ar_req_t     ar,
    output logic                    arvalid,
    input  logic                    arready,
    // AXI read data
    input  axi_rd_pkg::r_beat_t     beat,
    input  logic                    rvalid,
    output logic                    rready,
    // Encoder side
    output enc_pkg::quant_param_t   params,
    output logic                    reload,
    input  logic                    y0_full,
    input  logic                    y1_full,
    input  logic                    uv_full,
    output logic                    y0_wr,
    output logic                    y1_wr,
    output logic                    uv_wr,
    output logic [`RD_DATA_W-1:0]   fifo_din
);

    enc_pkg::job_cfg_t cfg;
    logic              start;
    logic              frame_done;
    logic              beat_error;
    logic              burst_done;

    rd_cfg_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .cfg        (cfg),
        .start      (start),
        .frame_done (frame_done),
        .beat_error (beat_error),
        .busy       ()
    );

    raddr_channel u_raddr (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .start      (start),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .burst_done (burst_done)
    );

    rdata_channel u_rdata (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .start      (start),
        .beat       (beat),
        .rvalid     (rvalid),
        .rready     (rready),
        .params     (params),
        .reload     (reload),
        .y0_full    (y0_full),
        .y1_full    (y1_full),
        .uv_full    (uv_full),
        .y0_wr      (y0_wr),
        .y1_wr      (y1_wr),
        .uv_wr      (uv_wr),
        .fifo_din   (fifo_din),
        .burst_done (burst_done),
        .beat_error (beat_error),
        .frame_done (frame_done)
    );

endmodule

// ==== hdl/axi_rd_pkg.sv ====
// AXI read side types. Side-band fields are fixed constants and are not carried here
`include "webp_rd_consts.svh"

package axi_rd_pkg;

    // Read address request as held on the AR channel
    typedef struct packed {
        logic [`RD_ADDR_W-1:0] araddr;
        logic [7:0]            arlen;
        logic [`RD_ID_W-1:0]   arid;
    } ar_req_t;

    // One beat on the R channel
    typedef struct packed {
        logic [`RD_DATA_W-1:0] rdata;
        logic [`RD_ID_W-1:0]   rid;
        logic [1:0]            rresp;
        logic                  rlast;
    } r_beat_t;

    // Job phase shared by the AR and R stages
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_DQM,
        PH_MB
    } rd_phase_e;

endpackage

// ==== hdl/enc_pkg.sv ====
// Encoder side types. The DQM block layout is fixed at four 128-bit beats
`include "webp_rd_consts.svh"

package enc_pkg;

    // Job setup written by software, stable while busy
    typedef struct packed {
        logic [`RD_ADDR_W-1:0] dqm_addr;
        logic [`RD_ADDR_W-1:0] src_addr;
        logic [5:0]            mb_w;
        logic [5:0]            mb_h;
    } job_cfg_t;

    // Quantizer parameters unpacked from the DQM block
    typedef struct packed {
        logic [31:0] lambda_i16;
        logic [31:0] lambda_i4;
        logic [31:0] lambda_uv;
        logic [31:0] tlambda;
        logic [31:0] lambda_mode;
        logic [31:0] min_disto;
        logic [31:0] max_edge;
        logic [63:0] y1_q;
        logic [63:0] y1_iq;
        logic [63:0] uv_q;
        logic [63:0] uv_iq;
    } quant_param_t;

    // Output FIFO selected by beat position in a macroblock
    typedef enum logic [1:0] {
        PL_Y0,
        PL_Y1,
        PL_UV
    } plane_e;

endpackage

// ==== hdl/raddr_channel.sv ====
// AR burst generator. Memory must return bursts in order and bases must be 512-byte aligned
`include "webp_rd_consts.svh"

module raddr_channel (
    input  logic                clk,
    input  logic                rst_n,
    input  enc_pkg::job_cfg_t   cfg,
    input  logic                start,
    output axi_rd_pkg::ar_req_t ar,
    output logic                arvalid,
    input  logic                arready,
    input  logic                burst_done
);

    localparam int OUT_W = $clog2(`MAX_OUTSTANDING + 1);
    localparam logic [7:0] DQM_LEN = 8'(`DQM_BEATS - 1);
    localparam logic [7:0] MB_LEN = 8'(`MB_BEATS - 1);

    axi_rd_pkg::rd_phase_e  phase;
    logic [11:0]            mb_total;
    logic [11:0]            mb_left;
    logic [`RD_ADDR_W-1:0]  mb_addr;
    logic [`RD_ID_W-1:0]    id_cnt;
    logic [`RD_ID_W-1:0]    id_nxt;
    logic [OUT_W-1:0]       out_cnt;
    logic [OUT_W-1:0]       out_nxt;
    logic                   accept;
    logic                   ar_free;
    logic                   launch_mb;

    assign mb_total = {6'd0, cfg.mb_w} * {6'd0, cfg.mb_h};
    assign accept   = arvalid && arready;
    assign ar_free  = !arvalid || accept;
    assign out_nxt  = out_cnt + OUT_W'(accept) - OUT_W'(burst_done);
    // Id for a request loaded this cycle
    assign id_nxt   = id_cnt + `RD_ID_W'(accept);

    // Next macroblock request once the slot is free and under the limit
    assign launch_mb = !start && (phase != axi_rd_pkg::PH_IDLE) && ar_free
                       && (mb_left != 12'd0) && (out_nxt < OUT_W'(`MAX_OUTSTANDING));

    // ------------------------------
    // Outstanding bursts and arid
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_cnt <= '0;
            id_cnt  <= '0;
        end
        else
        begin
            out_cnt <= out_nxt;
            if (start)
                id_cnt <= '0;
            else if (accept)
                id_cnt <= id_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Phase FSM and MB walk
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase   <= axi_rd_pkg::PH_IDLE;
            arvalid <= 1'b0;
            mb_left <= '0;
            mb_addr <= '0;
        end
        else if (start)
        begin
            phase   <= axi_rd_pkg::PH_DQM;
            arvalid <= 1'b1;
            mb_left <= mb_total;
            mb_addr <= cfg.src_addr;
        end
        else if (launch_mb)
        begin
            phase   <= axi_rd_pkg::PH_MB;
            arvalid <= 1'b1;
            mb_left <= mb_left - 12'd1;
            mb_addr <= mb_addr + `RD_ADDR_W'(`MB_BYTES);
        end
        else
        begin
            if (accept)
                arvalid <= 1'b0;
            // All requests accepted
            if (ar_free && mb_left == 12'd0)
                phase <= axi_rd_pkg::PH_IDLE;
        end
    end

    // Request payload
    always_ff @(posedge clk)
    begin
        if (start)
            ar <= '{araddr: cfg.dqm_addr, arlen: DQM_LEN, arid: '0};
        else if (launch_mb)
            ar <= '{araddr: mb_addr, arlen: MB_LEN, arid: id_nxt};
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));
    out_limit: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= OUT_W'(`MAX_OUTSTANDING));

endmodule

// ==== hdl/rd_cfg_regs.sv ====
// APB config block with pready tied high. Config writes are ignored while a job is busy
`include "webp_rd_consts.svh"

module rd_cfg_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output enc_pkg::job_cfg_t cfg,
    output logic              start,
    input  logic              frame_done,
    input  logic              beat_error,
    output logic              busy
);

    logic apb_wr;
    logic done;
    logic rd_error;

    assign apb_wr = psel && penable && pwrite;
    assign pready = 1'b1;

    // ------------------------------
    // Configuration registers
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cfg <= '0;
        else if (apb_wr && !busy)
        begin
            case (paddr)
                `REG_DQM_ADDR: cfg.dqm_addr <= pwdata;
                `REG_SRC_ADDR: cfg.src_addr <= pwdata;
                `REG_FRAME:
                begin
                    cfg.mb_w <= pwdata[5:0];
                    cfg.mb_h <= pwdata[13:8];
                end
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Go pulse and status
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            start    <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            rd_error <= 1'b0;
        end
        else
        begin
            start <= apb_wr && (paddr == `REG_CTRL) && pwdata[0] && !busy && !start;
            if (start)
            begin
                busy     <= 1'b1;
                done     <= 1'b0;
                rd_error <= 1'b0;
            end
            else
            begin
                if (frame_done)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                if (beat_error)
                    rd_error <= 1'b1;
            end
        end
    end

    // Read mux, CTRL reads back as zero
    always_comb
    begin
        case (paddr)
            `REG_STATUS:   prdata = {29'd0, rd_error, done, busy};
            `REG_DQM_ADDR: prdata = cfg.dqm_addr;
            `REG_SRC_ADDR: prdata = cfg.src_addr;
            `REG_FRAME:    prdata = {18'd0, cfg.mb_h, 2'd0, cfg.mb_w};
            default:       prdata = 32'd0;
        endcase
    end

    start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// ==== hdl/rdata_channel.sv ====
// R beat router. A bad rid or rresp is flagged but the beat is still used in place
`include "webp_rd_consts.svh"

module rdata_channel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  enc_pkg::job_cfg_t       cfg,
    input  logic                    start,
    input  axi_rd_pkg::r_beat_t     beat,
    input  logic                    rvalid,
    output logic                    rready,
    output enc_pkg::quant_param_t   params,
    output logic                    reload,
    input  logic                    y0_full,
    input  logic                    y1_full,
    input  logic                    uv_full,
    output logic                    y0_wr,
    output logic                    y1_wr,
    output logic                    uv_wr,
    output logic [`RD_DATA_W-1:0]   fifo_din,
    output logic                    burst_done,
    output logic                    beat_error,
    output logic                    frame_done
);

    localparam int IDX_W = $clog2(`MB_BEATS);
    localparam logic [IDX_W-1:0] Y1_FIRST = IDX_W'(`PLANE_BEATS);
    localparam logic [IDX_W-1:0] UV_FIRST = IDX_W'(2 * `PLANE_BEATS);

    axi_rd_pkg::rd_phase_e  phase;
    enc_pkg::plane_e        plane;
    logic [IDX_W-1:0]       beat_idx;
    logic [`RD_ID_W-1:0]    exp_id;
    logic [11:0]            mb_total;
    logic [11:0]            mb_left;
    logic                   sel_full;
    logic                   hs;
    logic                   mb_hs;
    logic                   dqm_hs;

    assign mb_total = {6'd0, cfg.mb_w} * {6'd0, cfg.mb_h};

    // ------------------------------
    // Plane select and handshake
    // ------------------------------
    always_comb
    begin
        if (beat_idx < Y1_FIRST)
            plane = enc_pkg::PL_Y0;
        else if (beat_idx < UV_FIRST)
            plane = enc_pkg::PL_Y1;
        else
            plane = enc_pkg::PL_UV;
    end

    always_comb
    begin
        case (plane)
            enc_pkg::PL_Y0: sel_full = y0_full;
            enc_pkg::PL_Y1: sel_full = y1_full;
            default:        sel_full = uv_full;
        endcase
    end

    always_comb
    begin
        case (phase)
            axi_rd_pkg::PH_DQM: rready = 1'b1;
            axi_rd_pkg::PH_MB:  rready = !sel_full;
            default:            rready = 1'b0;
        endcase
    end

    assign hs         = rvalid && rready;
    assign mb_hs      = hs && (phase == axi_rd_pkg::PH_MB);
    assign dqm_hs     = hs && (phase == axi_rd_pkg::PH_DQM) && (beat_idx < IDX_W'(`DQM_BEATS));
    assign burst_done = hs && beat.rlast;
    assign y0_wr      = mb_hs && (plane == enc_pkg::PL_Y0);
    assign y1_wr      = mb_hs && (plane == enc_pkg::PL_Y1);
    assign uv_wr      = mb_hs && (plane == enc_pkg::PL_UV);
    assign fifo_din   = beat.rdata;

    // ------------------------------
    // Beat, burst and MB tracking
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase      <= axi_rd_pkg::PH_IDLE;
            beat_idx   <= '0;
            exp_id     <= '0;
            mb_left    <= '0;
            reload     <= 1'b0;
            frame_done <= 1'b0;
            beat_error <= 1'b0;
        end
        else
        begin
            reload     <= 1'b0;
            frame_done <= 1'b0;
            beat_error <= hs && ((beat.rresp != 2'b00) || (beat.rid != exp_id));
            if (start)
            begin
                phase    <= axi_rd_pkg::PH_DQM;
                beat_idx <= '0;
                exp_id   <= '0;
                mb_left  <= mb_total;
            end
            else if (hs && beat.rlast)
            begin
                beat_idx <= '0;
                exp_id   <= exp_id + 1'b1;
                if (phase == axi_rd_pkg::PH_DQM)
                begin
                    reload <= 1'b1;
                    // Empty frame ends right after the parameters
                    if (mb_left == 12'd0)
                    begin
                        phase      <= axi_rd_pkg::PH_IDLE;
                        frame_done <= 1'b1;
                    end
                    else
                        phase <= axi_rd_pkg::PH_MB;
                end
                else
                begin
                    mb_left <= mb_left - 12'd1;
                    if (mb_left == 12'd1)
                    begin
                        phase      <= axi_rd_pkg::PH_IDLE;
                        frame_done <= 1'b1;
                    end
                end
            end
            else if (hs)
                beat_idx <= beat_idx + 1'b1;
        end
    end

    // DQM unpack, 32-bit lanes low to high
    always_ff @(posedge clk)
    begin
        if (dqm_hs)
        begin
            case (beat_idx[1:0])
                2'd0:
                begin
                    params.lambda_i16 <= beat.rdata[31:0];
                    params.lambda_i4  <= beat.rdata[63:32];
                    params.lambda_uv  <= beat.rdata[95:64];
                    params.tlambda    <= beat.rdata[127:96];
                end
                2'd1:
                begin
                    params.lambda_mode <= beat.rdata[31:0];
                    params.min_disto   <= beat.rdata[63:32];
                    params.max_edge    <= beat.rdata[95:64];
                end
                2'd2:
                begin
                    params.y1_q  <= beat.rdata[63:0];
                    params.y1_iq <= beat.rdata[127:64];
                end
                default:
                begin
                    params.uv_q  <= beat.rdata[63:0];
                    params.uv_iq <= beat.rdata[127:64];
                end
            endcase
        end
    end

    no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(y0_wr && y0_full) && !(y1_wr && y1_full) && !(uv_wr && uv_full));

endmodule

// ==== hdl/webp_rd_consts.svh ====
// Read master constants. Bases must be 512-byte aligned and frames are at most 63x63 MBs
`ifndef WEBP_RD_CONSTS_SVH
`define WEBP_RD_CONSTS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define RD_DATA_W        128
`define RD_ADDR_W        32
`define RD_ID_W          2

// ------------------------------
// Burst geometry
// ------------------------------
`define MB_BEATS         24
`define PLANE_BEATS      8
`define DQM_BEATS        4
// Byte stride between macroblocks in memory
`define MB_BYTES         384
`define MAX_OUTSTANDING  4

// ------------------------------
// APB register byte offsets
// ------------------------------
`define REG_CTRL         8'h00
`define REG_STATUS       8'h04
`define REG_DQM_ADDR     8'h08
`define REG_SRC_ADDR     8'h0C
`define REG_FRAME        8'h10

`endif

// ==== test/axi_mem_model.sv ====
// AXI read slave for simulation only. Bursts are served in issue order and data depends on address
`include "webp_rd_consts.svh"

module axi_mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                job_clr,
    input  int                  err_beat,
    input  axi_rd_pkg::ar_req_t ar,
    input  logic                arvalid,
    output logic                arready,
    output axi_rd_pkg::r_beat_t beat,
    output logic                rvalid,
    input  logic                rready
);
    timeunit 1ns;
    timeprecision 100ps;

    axi_rd_pkg::ar_req_t pending[$];
    int                  beat_no;
    int                  job_beat;
    logic                r_taken;

    // Each 32-bit lane is its byte address XOR a fixed pattern
    function automatic logic [`RD_DATA_W-1:0] beat_data(logic [31:0] addr);
        logic [`RD_DATA_W-1:0] d;
        for (int k = 0; k < `RD_DATA_W / 32; k++)
            d[k*32 +: 32] = (addr + 32'(k * 4)) ^ 32'h5a5a0000;
        return d;
    endfunction

    initial
    begin
        arready  = 1'b0;
        rvalid   = 1'b0;
        beat     = '0;
        beat_no  = 0;
        job_beat = 0;
        r_taken  = 1'b0;
        forever
        begin
            // Handshakes seen at the rising edge
            @(posedge clk);
            r_taken = rvalid && rready;
            if (!rst_n)
                pending.delete();
            if (job_clr)
                job_beat = 0;
            if (arvalid && arready)
                pending.push_back(ar);
            if (r_taken)
            begin
                job_beat++;
                if (beat_no == int'(pending[0].arlen))
                begin
                    void'(pending.pop_front());
                    beat_no = 0;
                end
                else
                    beat_no++;
            end

            // New outputs on the falling edge
            @(negedge clk);
            if (!rst_n)
            begin
                arready = 1'b0;
                rvalid  = 1'b0;
                beat    = '0;
            end
            else
            begin
                arready = ($urandom % 4) != 0;
                // A presented beat stays put until it is taken
                if (!rvalid || r_taken)
                begin
                    rvalid = 1'b0;
                    if (pending.size() > 0 && ($urandom % 4) != 0)
                    begin
                        rvalid     = 1'b1;
                        beat.rdata = beat_data(pending[0].araddr + 32'(beat_no * 16));
                        beat.rid   = pending[0].arid;
                        beat.rresp = (job_beat == err_beat) ? 2'b10 : 2'b00;
                        beat.rlast = beat_no == int'(pending[0].arlen);
                    end
                end
            end
        end
    end

endmodule

// ==== test/rd_input.txt ====
# dqm_addr(hex) src_addr(hex) mb_w mb_h err_beat status_after_done(hex)
# err_beat counts beats from 0 at the first DQM beat of the job, -1 means no error
00001000 00100000 1 1 -1 2
00002200 00200000 3 2 -1 2
00000400 00380000 4 4 -1 2
00003000 00400000 2 3 10 6
00001e00 00500000 2 2 -1 2
00000200 00610000 8 6 -1 2
00004000 00700000 5 3 2 6
0000fe00 00800000 1 2 -1 2
00010000 00f00000 3 1 100 2
00020000 00a00000 6 1 75 6
00030000 00b00000 2 1 -1 2

// ==== test/tb_axi_master_rd.sv ====
// Jobs come from test/rd_input.txt relative to the project root. Expected data is rebuilt from addresses
`include "webp_rd_consts.svh"

module tb_axi_master_rd;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int POLL_LIMIT = 20000;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [7:0]            paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    axi_rd_pkg::ar_req_t   ar;
    logic                  arvalid;
    logic                  arready;
    axi_rd_pkg::r_beat_t   beat;
    logic                  rvalid;
    logic                  rready;
    enc_pkg::quant_param_t params;
    logic                  reload;
    logic                  y0_full = 1'b0;
    logic                  y1_full = 1'b0;
    logic                  uv_full = 1'b0;
    logic                  y0_wr;
    logic                  y1_wr;
    logic                  uv_wr;
    logic [`RD_DATA_W-1:0] fifo_din;
    logic                  job_clr;
    int                    err_beat;

    // Current job, shared with the monitors
    logic [31:0]           dqm_addr;
    logic [31:0]           src_addr;
    int                    ar_cnt;
    int                    reload_cnt;
    int                    wr_cnt [3];
    int                    r_cnt;

    axi_master_rd dut (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .beat(beat), .rvalid(rvalid), .rready(rready),
        .params(params), .reload(reload),
        .y0_full(y0_full), .y1_full(y1_full), .uv_full(uv_full),
        .y0_wr(y0_wr), .y1_wr(y1_wr), .uv_wr(uv_wr), .fifo_din(fifo_din)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .job_clr(job_clr), .err_beat(err_beat),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .beat(beat), .rvalid(rvalid), .rready(rready)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // Expected values and checks
    // ------------------------------
    function automatic logic [31:0] lane_at(logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    // Consecutive lanes from addr upward, low lane first
    function automatic logic [`RD_DATA_W-1:0] lanes_at(logic [31:0] addr, int words);
        logic [`RD_DATA_W-1:0] v;
        v = '0;
        for (int k = 0; k < words; k++)
            v[k*32 +: 32] = lane_at(addr + 32'(k * 4));
        return v;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic expect_eq(string name, logic [`RD_DATA_W-1:0] got,
                             logic [`RD_DATA_W-1:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
    endtask

    task automatic check_fifo(enc_pkg::plane_e pl, logic full, string name);
        int          mb;
        int          idx;
        logic [31:0] addr;
        mb   = wr_cnt[int'(pl)] / `PLANE_BEATS;
        idx  = int'(pl) * `PLANE_BEATS + wr_cnt[int'(pl)] % `PLANE_BEATS;
        addr = src_addr + 32'(mb * `MB_BYTES + idx * 16);
        assert (!full)
        else
            abort_run({name, " asserted while its FIFO was full"});
        expect_eq({name, " fifo_din"}, fifo_din, lanes_at(addr, 4));
        wr_cnt[int'(pl)]++;
    endtask

    // DQM beats are always taken, MB beats only when their FIFO has room
    task automatic check_rready();
        int   pos;
        logic room;
        if (r_cnt < `DQM_BEATS)
            room = 1'b1;
        else
        begin
            pos  = ((r_cnt - `DQM_BEATS) % `MB_BEATS) / `PLANE_BEATS;
            room = !(pos == 0 ? y0_full : (pos == 1 ? y1_full : uv_full));
        end
        expect_eq("rready", `RD_DATA_W'(rready), `RD_DATA_W'(room));
        if (rready)
            r_cnt++;
    endtask

    task automatic check_ar();
        logic [31:0] exp_addr;
        logic [7:0]  exp_len;
        // Burst 0 is the DQM block, then MBs in raster order
        if (ar_cnt == 0)
        begin
            exp_addr = dqm_addr;
            exp_len  = 8'(`DQM_BEATS - 1);
        end
        else
        begin
            exp_addr = src_addr + 32'((ar_cnt - 1) * `MB_BYTES);
            exp_len  = 8'(`MB_BEATS - 1);
        end
        expect_eq("araddr", `RD_DATA_W'(ar.araddr), `RD_DATA_W'(exp_addr));
        expect_eq("arlen", `RD_DATA_W'(ar.arlen), `RD_DATA_W'(exp_len));
        expect_eq("arid", `RD_DATA_W'(ar.arid), `RD_DATA_W'(ar_cnt % (1 << `RD_ID_W)));
        ar_cnt++;
    endtask

    task automatic check_params();
        logic [31:0] a;
        a = dqm_addr;
        expect_eq("lambda_i16", `RD_DATA_W'(params.lambda_i16), lanes_at(a, 1));
        expect_eq("lambda_i4", `RD_DATA_W'(params.lambda_i4), lanes_at(a + 4, 1));
        expect_eq("lambda_uv", `RD_DATA_W'(params.lambda_uv), lanes_at(a + 8, 1));
        expect_eq("tlambda", `RD_DATA_W'(params.tlambda), lanes_at(a + 12, 1));
        expect_eq("lambda_mode", `RD_DATA_W'(params.lambda_mode), lanes_at(a + 16, 1));
        expect_eq("min_disto", `RD_DATA_W'(params.min_disto), lanes_at(a + 20, 1));
        expect_eq("max_edge", `RD_DATA_W'(params.max_edge), lanes_at(a + 24, 1));
        expect_eq("y1_q", `RD_DATA_W'(params.y1_q), lanes_at(a + 32, 2));
        expect_eq("y1_iq", `RD_DATA_W'(params.y1_iq), lanes_at(a + 40, 2));
        expect_eq("uv_q", `RD_DATA_W'(params.uv_q), lanes_at(a + 48, 2));
        expect_eq("uv_iq", `RD_DATA_W'(params.uv_iq), lanes_at(a + 56, 2));
        reload_cnt++;
    endtask

    // Monitors sample at the rising edge
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (y0_wr)
                check_fifo(enc_pkg::PL_Y0, y0_full, "y0_wr");
            if (y1_wr)
                check_fifo(enc_pkg::PL_Y1, y1_full, "y1_wr");
            if (uv_wr)
                check_fifo(enc_pkg::PL_UV, uv_full, "uv_wr");
            if (rvalid)
                check_rready();
            if (arvalid && arready)
                check_ar();
            if (reload)
                check_params();
        end
    end

    // Random FIFO back-pressure
    always @(negedge clk)
    begin
        y0_full = rst_n && (($urandom % 4) == 0);
        y1_full = rst_n && (($urandom % 4) == 0);
        uv_full = rst_n && (($urandom % 4) == 0);
    end

    // ------------------------------
    // APB access and job sequence
    // ------------------------------
    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        assert (pready)
        else
            abort_run("APB pready was low in the access phase");
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_job(logic [31:0] dqm, logic [31:0] src, int w, int h, int err,
                           logic [31:0] exp_status);
        logic [31:0] rd;
        logic [31:0] frame;
        int          polls;
        int          mbs;
        mbs        = w * h;
        frame      = {18'd0, 6'(h), 2'd0, 6'(w)};
        dqm_addr   = dqm;
        src_addr   = src;
        ar_cnt     = 0;
        reload_cnt = 0;
        wr_cnt     = '{0, 0, 0};
        r_cnt      = 0;
        err_beat   = err;
        @(negedge clk);
        job_clr = 1'b1;
        @(negedge clk);
        job_clr = 1'b0;

        apb_write(`REG_DQM_ADDR, dqm);
        apb_write(`REG_SRC_ADDR, src);
        apb_write(`REG_FRAME, frame);
        apb_read(`REG_DQM_ADDR, rd);
        expect_eq("DQM_ADDR", `RD_DATA_W'(rd), `RD_DATA_W'(dqm));
        apb_read(`REG_SRC_ADDR, rd);
        expect_eq("SRC_ADDR", `RD_DATA_W'(rd), `RD_DATA_W'(src));
        apb_read(`REG_FRAME, rd);
        expect_eq("FRAME", `RD_DATA_W'(rd), `RD_DATA_W'(frame));

        apb_write(`REG_CTRL, 32'd1);
        rd    = '0;
        polls = 0;
        while (!rd[1] && polls < POLL_LIMIT)
        begin
            apb_read(`REG_STATUS, rd);
            polls++;
        end
        if (!rd[1])
            abort_run("timeout waiting for the done bit in STATUS");

        expect_eq("STATUS", `RD_DATA_W'(rd), `RD_DATA_W'(exp_status));
        expect_eq("AR burst count", `RD_DATA_W'(ar_cnt), `RD_DATA_W'(mbs + 1));
        expect_eq("reload count", `RD_DATA_W'(reload_cnt), `RD_DATA_W'(1));
        expect_eq("y0_wr count", `RD_DATA_W'(wr_cnt[0]), `RD_DATA_W'(mbs * `PLANE_BEATS));
        expect_eq("y1_wr count", `RD_DATA_W'(wr_cnt[1]), `RD_DATA_W'(mbs * `PLANE_BEATS));
        expect_eq("uv_wr count", `RD_DATA_W'(wr_cnt[2]), `RD_DATA_W'(mbs * `PLANE_BEATS));
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          jobs;
        int          w;
        int          h;
        int          err;
        string       line;
        logic [31:0] dqm;
        logic [31:0] src;
        logic [31:0] st;
        void'($urandom(32'hf43e3c1e));
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        job_clr    = 1'b0;
        err_beat   = -1;
        dqm_addr   = '0;
        src_addr   = '0;
        ar_cnt     = 0;
        reload_cnt = 0;
        wr_cnt     = '{0, 0, 0};
        r_cnt      = 0;
        jobs       = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("test/rd_input.txt", "r");
        if (fd == 0)
            abort_run("could not open test/rd_input.txt");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %h %d %d %d %h", dqm, src, w, h, err, st);
                if (n != 6)
                    abort_run({"malformed job line: ", line});
                run_job(dqm, src, w, h, err, st);
                jobs++;
            end
        end
        $fclose(fd);

        if (jobs == 0)
            abort_run("no jobs found in test/rd_input.txt");
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
